// ==== all.f ====
+incdir+.
fir_pkg.sv
fir_tap_line.sv
fir_coeff_mult.sv
fir_adder_tree.sv
fir_top.sv
fir_tb_clock.sv
fir_sva.sv
fir_tb.sv

// ==== fir_adder_tree.sv ====
/*
 * five level registered adder tree, 26 products down to one sum
 * bypass registers align odd leftovers
 */
`timescale 1ns/1ps
`include "fir_params.svh"

module fir_adder_tree (
	input  logic                clk,
	input  logic                reset,
	input  logic                i_clk_ena,
	input  fir_pkg::prod_vec_t  i_prods,
	output fir_pkg::sample_t    o_sample
);

	// node counts per level: 13, 7, 4, 2, 1
	localparam int L1_N  = (`FIR_NUNIQ + 1) / 2;
	localparam int L2_N  = (L1_N + 1) / 2;
	localparam int L3_N  = (L2_N + 1) / 2;
	localparam int L4_N  = (L3_N + 1) / 2;
	localparam int DEPTH = 5;

	fir_pkg::word_t  lvl1_q [L1_N];
	fir_pkg::word_t  lvl2_q [L2_N];
	fir_pkg::word_t  lvl3_q [L3_N];
	fir_pkg::word_t  lvl4_q [L4_N];
	fir_pkg::word_t  lvl5_q;
	logic [DEPTH-1:0] valid_q;

	// ******************************
	// level 1
	// ******************************

	// even count, neighbors pair up cleanly
	always_ff @(posedge clk) begin
		if (i_clk_ena) begin
			for (int k = 0; k < L1_N; k++) begin
				lvl1_q[k] <= i_prods.prod[2*k] + i_prods.prod[2*k+1];
			end
		end
	end

	// ******************************
	// levels 2 and 3
	// ******************************

	// 13 inputs, last one rides a bypass register
	always_ff @(posedge clk) begin
		if (i_clk_ena) begin
			for (int k = 0; k < L2_N - 1; k++) begin
				lvl2_q[k] <= lvl1_q[2*k] + lvl1_q[2*k+1];
			end
			lvl2_q[L2_N-1] <= lvl1_q[L1_N-1];
		end
	end

	// 7 inputs, same bypass trick
	always_ff @(posedge clk) begin
		if (i_clk_ena) begin
			for (int k = 0; k < L3_N - 1; k++) begin
				lvl3_q[k] <= lvl2_q[2*k] + lvl2_q[2*k+1];
			end
			lvl3_q[L3_N-1] <= lvl2_q[L2_N-1];
		end
	end

	// ******************************
	// levels 4 and 5
	// ******************************

	always_ff @(posedge clk) begin
		if (i_clk_ena) begin
			for (int k = 0; k < L4_N; k++) begin
				lvl4_q[k] <= lvl3_q[2*k] + lvl3_q[2*k+1];
			end
			// final sum wraps like every other add
			lvl5_q <= lvl4_q[0] + lvl4_q[1];
		end
	end

	// valid follows the data through all five levels
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_q <= '0;
		end else if (i_clk_ena) begin
			valid_q <= {valid_q[DEPTH-2:0], i_prods.valid};
		end
	end

	assign o_sample.valid = valid_q[DEPTH-1];
	assign o_sample.data  = lvl5_q;

endmodule

// ==== fir_coeff_mult.sv ====
/*
 * registered coefficient multiplies with product scaling
 */
`timescale 1ns/1ps
`include "fir_params.svh"

module fir_coeff_mult (
	input  logic                clk,
	input  logic                reset,
	input  logic                i_clk_ena,
	input  fir_pkg::pair_vec_t  i_pairs,
	output fir_pkg::prod_vec_t  o_prods
);

	logic signed [`FIR_MULT_W-1:0]     full_prod [`FIR_NUNIQ];
	logic signed [`FIR_MULT_W-1:0]     scaled    [`FIR_NUNIQ];
	fir_pkg::word_t [`FIR_NUNIQ-1:0]   prod_q;
	logic                              prod_valid_q;

	// ******************************
	// multiply and scale
	// ******************************

	// full width product, then arithmetic shift keeps the sign
	always_comb begin
		for (int k = 0; k < `FIR_NUNIQ; k++) begin
			full_prod[k] = $signed(i_pairs.pair[k]) * $signed(fir_pkg::COEFFS[k]);
			scaled[k]    = full_prod[k] >>> `FIR_SCALE;
		end
	end

	// low word only, upper bits drop
	always_ff @(posedge clk) begin
		if (i_clk_ena) begin
			for (int k = 0; k < `FIR_NUNIQ; k++) begin
				prod_q[k] <= scaled[k][`FIR_DW-1:0];
			end
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			prod_valid_q <= 1'b0;
		end else if (i_clk_ena) begin
			prod_valid_q <= i_pairs.valid;
		end
	end

	assign o_prods.valid = prod_valid_q;
	assign o_prods.prod  = prod_q;

endmodule

// ==== fir_params.svh ====
/*
 * FIR filter sizing macros
 * data width, tap counts, product width and scale shift
 */
`ifndef FIR_PARAMS_SVH
`define FIR_PARAMS_SVH

// ******************************
// datapath widths
// ******************************

// sample width, also used for every internal add
`define FIR_DW 18

// full signed product of two samples
`define FIR_MULT_W 36

// ******************************
// filter shape
// ******************************

// total taps, odd length so there is one center tap
`define FIR_NTAPS 51

// mirrored pairs plus the center tap
`define FIR_NUNIQ 26

// arithmetic right shift applied to each product
`define FIR_SCALE 17

`endif

// ==== fir_pkg.sv ====
/*
 * shared FIR types: datapath word, sample, pair and product vectors
 * symmetric coefficient table
 */
`include "fir_params.svh"

package fir_pkg;

	// signed datapath word, elements of the vectors below stay signed
	typedef logic signed [`FIR_DW-1:0] word_t;

	// one sample with its strobe, 19 bits
	typedef struct packed {
		logic  valid;
		word_t data;
	} sample_t;

	// pre-added mirrored taps, index 25 is the bare center tap
	typedef struct packed {
		logic                    valid;
		word_t [`FIR_NUNIQ-1:0]  pair;
	} pair_vec_t;

	// scaled products, same order as the pairs
	typedef struct packed {
		logic                    valid;
		word_t [`FIR_NUNIQ-1:0]  prod;
	} prod_vec_t;

	// ******************************
	// coefficient table
	// ******************************

	// entry k weights taps k and 50-k, entry 25 the center tap
	localparam word_t COEFFS [`FIR_NUNIQ] = '{
		18'sd88,    18'sd0,     -18'sd97,   -18'sd197,
		-18'sd294,  -18'sd380,  -18'sd447,  -18'sd490,
		-18'sd504,  -18'sd481,  -18'sd420,  -18'sd319,
		-18'sd178,  18'sd0,     18'sd212,   18'sd451,
		18'sd710,   18'sd980,   18'sd1252,  18'sd1514,
		18'sd1756,  18'sd1971,  18'sd2147,  18'sd2278,
		18'sd2360,
		// peak of the impulse response
		18'sd2387
	};

endpackage

// ==== fir_sva.sv ====
/*
 * bound assertions on fir_top: reset state and output hold on stalls
 */
`timescale 1ns/1ps

module fir_sva (
	input logic              clk,
	input logic              reset,
	input logic              i_clk_ena,
	input fir_pkg::sample_t  i_out_sample
);

	// no result may leave the filter while reset is held
	reset_clears_valid: assert property (@(posedge clk) reset |-> !i_out_sample.valid)
		else $error("output valid high during reset");

	// a disabled edge freezes the strobe
	stall_holds_valid: assert property (@(posedge clk) disable iff (reset)
		!i_clk_ena |=> $stable(i_out_sample.valid))
		else $error("output valid changed on a disabled edge");

	// data only matters while valid is high
	stall_holds_data: assert property (@(posedge clk) disable iff (reset)
		(!i_clk_ena && i_out_sample.valid) |=> $stable(i_out_sample.data))
		else $error("output data changed on a disabled edge");

endmodule

bind fir_top fir_sva sva_i (
	.clk          (clk),
	.reset        (reset),
	.i_clk_ena    (i_clk_ena),
	.i_out_sample (o_sample)
);

// ==== fir_tap_line.sv ====
/*
 * sample delay line with registered symmetric pre-add
 */
`timescale 1ns/1ps
`include "fir_params.svh"

module fir_tap_line (
	input  logic                clk,
	input  logic                reset,
	input  logic                i_clk_ena,
	input  fir_pkg::sample_t    i_sample,
	output fir_pkg::pair_vec_t  o_pairs
);

	// center tap sits at the midpoint of the line
	localparam int CENTER = (`FIR_NTAPS - 1) / 2;

	fir_pkg::word_t                    taps_q [`FIR_NTAPS];
	logic                              line_valid_q;
	fir_pkg::word_t [`FIR_NUNIQ-1:0]   pair_d;
	fir_pkg::word_t [`FIR_NUNIQ-1:0]   pair_q;
	logic                              pair_valid_q;

	// ******************************
	// delay line
	// ******************************

	// every enabled edge shifts, so invalid samples still fill history
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int k = 0; k < `FIR_NTAPS; k++) begin
				taps_q[k] <= '0;
			end
			line_valid_q <= 1'b0;
		end else if (i_clk_ena) begin
			taps_q[0] <= i_sample.data;
			for (int k = 1; k < `FIR_NTAPS; k++) begin
				taps_q[k] <= taps_q[k-1];
			end
			line_valid_q <= i_sample.valid;
		end
	end

	// ******************************
	// symmetric pre-add
	// ******************************

	// fold tap k with its mirror, sum wraps at the word width
	always_comb begin
		for (int k = 0; k < CENTER; k++) begin
			pair_d[k] = taps_q[k] + taps_q[`FIR_NTAPS-1-k];
		end
		pair_d[CENTER] = taps_q[CENTER];
	end

	always_ff @(posedge clk) begin
		if (i_clk_ena) begin
			pair_q <= pair_d;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pair_valid_q <= 1'b0;
		end else if (i_clk_ena) begin
			pair_valid_q <= line_valid_q;
		end
	end

	assign o_pairs.valid = pair_valid_q;
	assign o_pairs.pair  = pair_q;

endmodule

// ==== fir_tb.sv ====
/*
 * FIR testbench: reads the test table, drives the DUT on falling edges,
 * checks each result against the table and runs a watchdog
 */
`timescale 1ns/1ps
`include "fir_params.svh"

module fir_tb;

	localparam int CLK_PERIOD   = 100;
	localparam int RESET_CYCLES = 16;
	// eight pipeline registers from input to output
	localparam int LATENCY      = 8;

	logic              clk;
	logic              reset;
	logic              i_clk_ena;
	fir_pkg::sample_t  i_sample;
	fir_pkg::sample_t  o_sample;

	int                mismatches;
	int                other_errors;
	bit                loaded;
	logic [31:0]       lcg_state;
	fir_pkg::sample_t  held;
	int                ena_edges;

	// test table columns
	fir_pkg::word_t    stim_data [$];
	bit                stim_valid [$];
	bit                stim_stall [$];
	fir_pkg::word_t    stim_exp [$];

	// results still owed by the pipeline
	fir_pkg::word_t    exp_q [$];
	// enabled edge count at which each owed result shows
	int                due_q [$];

	fir_tb_clock #(.PERIOD(CLK_PERIOD)) clock_i (.o_clk(clk));

	fir_top fir_top_i (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_sample  (i_sample),
		.o_sample  (o_sample)
	);

	// ******************************
	// helpers
	// ******************************

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic load_tests();
		int    fd;
		int    n;
		int    s;
		int    v;
		int    st;
		int    e;
		string line;
		fd = $fopen("fir_tests.txt", "r");
		if (fd == 0) begin
			other_errors++;
			$display("could not open the test table fir_tests.txt");
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() == 0 || line[0] == "#") begin
				continue;
			end
			n = $sscanf(line, "%d %d %d %d", s, v, st, e);
			// blank or short lines carry no test
			if (n != 4) begin
				continue;
			end
			stim_data.push_back(fir_pkg::word_t'(s));
			stim_valid.push_back(v != 0);
			stim_stall.push_back(st != 0);
			stim_exp.push_back(fir_pkg::word_t'(e));
		end
		$fclose(fd);
	endtask

	task automatic compare_sample(input fir_pkg::sample_t got, input fir_pkg::sample_t expected,
		input string what);
		if (got !== expected) begin
			mismatches++;
			$display("mismatch at %0t ns: %s, got valid %b data %0d, expected valid %b data %0d",
				$time, what, got.valid, got.data, expected.valid, expected.data);
		end
	endtask

	// looks at the edge that just passed, i_clk_ena still holds its value
	task automatic check_edge();
		fir_pkg::sample_t expected;
		int               due;
		if (!i_clk_ena) begin
			compare_sample(o_sample, held, "output moved during a stall");
		end else begin
			ena_edges++;
			if (o_sample.valid) begin
				if (exp_q.size() == 0) begin
					other_errors++;
					$display("output valid at %0t ns with no sample pending", $time);
				end else begin
					expected.valid = 1'b1;
					expected.data  = exp_q.pop_front();
					due            = due_q.pop_front();
					compare_sample(o_sample, expected, "filter output");
					if (due != ena_edges) begin
						other_errors++;
						$display("result at %0t ns took %0d enabled cycles instead of %0d",
							$time, ena_edges - due + LATENCY, LATENCY);
					end
				end
			end else if (due_q.size() != 0 && due_q[0] == ena_edges) begin
				other_errors++;
				$display("no valid output at %0t ns where a result was due", $time);
			end
		end
		held = o_sample;
	endtask

	// ******************************
	// stimulus
	// ******************************

	initial begin
		logic [31:0] rnd;
		mismatches   = 0;
		other_errors = 0;
		loaded       = 1'b0;
		ena_edges    = 0;
		lcg_state    = 32'h16f3;
		reset        = 1'b1;
		i_clk_ena    = 1'b0;
		i_sample     = '0;
		load_tests();
		if (stim_data.size() == 0) begin
			other_errors++;
			$display("the test table holds no test lines");
		end
		loaded = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset     = 1'b0;
		i_clk_ena = 1'b1;
		held      = o_sample;

		for (int i = 0; i < stim_data.size(); i++) begin
			// stall gaps only where the table allows them
			if (stim_stall[i]) begin
				rnd = lcg_next();
				while (rnd[31:30] == 2'b00) begin
					i_clk_ena      = 1'b0;
					i_sample.valid = 1'b0;
					@(negedge clk);
					check_edge();
					rnd = lcg_next();
				end
			end
			i_clk_ena      = 1'b1;
			i_sample.valid = stim_valid[i];
			i_sample.data  = stim_data[i];
			if (stim_valid[i]) begin
				exp_q.push_back(stim_exp[i]);
				// counted from the enabled edge that takes this sample
				due_q.push_back(ena_edges + LATENCY);
			end
			@(negedge clk);
			check_edge();
		end

		// drain the pipeline, then watch for stray results
		i_clk_ena = 1'b1;
		i_sample  = '0;
		while (exp_q.size() != 0) begin
			@(negedge clk);
			check_edge();
		end
		repeat (4) begin
			@(negedge clk);
			check_edge();
		end

		$display("summary: %0d mismatches, %0d other errors", mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	// ******************************
	// watchdog
	// ******************************

	initial begin
		wait (loaded);
		#(stim_data.size() * 4 * CLK_PERIOD);
		$display("timeout: the pipeline did not finish within %0d clock periods",
			stim_data.size() * 4);
		$display("summary: %0d mismatches, %0d other errors", mismatches, other_errors);
		$display("Done: errors found");
		$finish;
	end

endmodule

// ==== fir_tb_clock.sv ====
/*
 * testbench clock generator
 */
`timescale 1ns/1ps

module fir_tb_clock #(
	parameter int PERIOD = 100
) (
	output logic o_clk
);

	// free running, starts low
	initial begin
		o_clk = 1'b0;
		forever begin
			#(PERIOD / 2) o_clk = ~o_clk;
		end
	end

endmodule

// ==== fir_tests.txt ====
# columns: sample valid stall_ok expected (decimal, expected read only where valid is 1)
# stall_ok 1 lets the testbench drop the clock enable before that line
# impulse of 2^17-1, outputs are the scaled coefficients in symmetric order
131071 1 1 87
0 1 1 0
0 1 1 -97
0 1 1 -197
0 1 1 -294
0 1 1 -380
0 1 1 -447
0 1 1 -490
0 1 1 -504
0 1 1 -481
0 1 1 -420
0 1 1 -319
0 1 1 -178
0 1 1 0
0 1 1 211
0 1 1 450
0 1 1 709
0 1 1 979
0 1 1 1251
0 1 1 1513
0 1 1 1755
0 1 1 1970
0 1 1 2146
0 1 1 2277
0 1 1 2359
0 1 1 2386
0 1 1 2359
0 1 1 2277
0 1 1 2146
0 1 1 1970
0 1 1 1755
0 1 1 1513
0 1 1 1251
0 1 1 979
0 1 1 709
0 1 1 450
0 1 1 211
0 1 1 0
0 1 1 -178
0 1 1 -319
0 1 1 -420
0 1 1 -481
0 1 1 -504
0 1 1 -490
0 1 1 -447
0 1 1 -380
0 1 1 -294
0 1 1 -197
0 1 1 -97
0 1 1 0
0 1 1 87
# step of 2^16, fill lines unchecked, settled value is the wrapped scaled sum
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 0 0 0
65536 1 0 -10719
65536 1 0 -10719
65536 1 0 -10719

// ==== fir_top.sv ====
/*
 * FIR top level: tap line, multiplier and adder tree
 */
`timescale 1ns/1ps

module fir_top (
	input  logic              clk,
	input  logic              reset,
	input  logic              i_clk_ena,
	input  fir_pkg::sample_t  i_sample,
	output fir_pkg::sample_t  o_sample
);

	// stage to stage vectors
	fir_pkg::pair_vec_t  pairs;
	fir_pkg::prod_vec_t  prods;

	// ******************************
	// pipeline stages
	// ******************************

	// delay line and pre-add, 2 cycles
	fir_tap_line tap_line_i (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_sample  (i_sample),
		.o_pairs   (pairs)
	);

	// scaled coefficient products, 1 cycle
	fir_coeff_mult coeff_mult_i (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_pairs   (pairs),
		.o_prods   (prods)
	);

	// reduction to one sum, 5 cycles
	fir_adder_tree adder_tree_i (
		.clk       (clk),
		.reset     (reset),
		.i_clk_ena (i_clk_ena),
		.i_prods   (prods),
		.o_sample  (o_sample)
	);

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the FIR testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module fir_tb \
	-f all.f \
	-o fir_sim

./obj_dir/fir_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "Done: no errors" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
